//--- sim/rename_stimulus.txt
# sq rv a0 a1 tv t0 t1 p0 p1  ev e0 e1 o0 o1 fc   (all hex, lane 0 before lane 1)
# inputs, then expected prn_valid, prn, old prn and free_count; e* where ev set, o* where rv set
# fresh renames after reset
0 3 01 02 0 00 00 00 00  3 20 21 01 02 20
0 0 00 00 0 00 00 00 00  0 00 00 00 00 1e
# same register in both lanes, upper lane sees the lower lane's new reg
0 3 05 05 0 00 00 00 00  3 22 23 05 22 1e
0 3 05 01 0 00 00 00 00  3 24 25 23 20 1c
# drain the speculative free list
0 3 06 07 0 00 00 00 00  3 26 27 06 07 1a
0 3 06 07 0 00 00 00 00  3 28 29 26 27 18
0 3 06 07 0 00 00 00 00  3 2a 2b 28 29 16
0 3 06 07 0 00 00 00 00  3 2c 2d 2a 2b 14
0 3 06 07 0 00 00 00 00  3 2e 2f 2c 2d 12
0 3 06 07 0 00 00 00 00  3 30 31 2e 2f 10
0 3 06 07 0 00 00 00 00  3 32 33 30 31 0e
0 3 06 07 0 00 00 00 00  3 34 35 32 33 0c
0 3 06 07 0 00 00 00 00  3 36 37 34 35 0a
0 3 06 07 0 00 00 00 00  3 38 39 36 37 08
0 3 06 07 0 00 00 00 00  3 3a 3b 38 39 06
0 3 06 07 0 00 00 00 00  3 3c 3d 3a 3b 04
0 3 06 07 0 00 00 00 00  3 3e 3f 3c 3d 02
# empty list, no grant and no map change
0 3 06 07 0 00 00 00 00  0 00 00 3e 3f 00
0 1 06 00 0 00 00 00 00  0 00 00 3e 00 00
# retirement frees the committed mappings, reused in FIFO order
0 0 00 00 3 01 02 20 21  0 00 00 00 00 00
0 3 08 09 3 05 05 22 23  3 01 02 08 09 02
0 3 0a 0b 3 05 01 24 25  3 05 22 0a 0b 02
0 0 00 00 0 00 00 00 00  0 00 00 00 00 02
# speculative renames, then squash back to the committed state
0 3 01 02 0 00 00 00 00  3 23 20 25 21 02
1 0 00 00 0 00 00 00 00  0 00 00 00 00 00
0 3 01 02 0 00 00 00 00  3 26 27 25 21 20
0 3 05 06 0 00 00 00 00  3 28 29 24 06 1e
# upper lane alone
0 2 00 03 0 00 00 00 00  2 00 2a 00 03 1c
0 0 00 00 0 00 00 00 00  0 00 00 00 00 1b

//--- sim/rename_unit_checker.sv
`timescale 1ns/100ps
`include "rename_cfg.svh"

module rename_unit_checker (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     squash,
    input  logic [`N-1:0]            retire_valid,
    input  logic [`N-1:0]            rename_prn_valid,
    input  free_list_pkg::fl_count_t free_count
);

    int fail_count = 0; // read by the testbench

    // a flush and a commit never share a cycle
    no_retire_on_squash: assert property (@(posedge clock) disable iff (reset)
        squash |-> retire_valid == '0)
        else begin
            $error("retirement requested in a squash cycle");
            fail_count++;
        end

    count_in_range: assert property (@(posedge clock) disable iff (reset)
        free_count <= `PHYS_REG_SZ)
        else begin
            $error("free list count above the number of physical registers");
            fail_count++;
        end

    no_pop_when_empty: assert property (@(posedge clock) disable iff (reset)
        free_count == '0 |-> rename_prn_valid == '0)
        else begin
            $error("rename lane got a register from an empty free list");
            fail_count++;
        end

endmodule

bind rename_unit rename_unit_checker protocol_chk (
    .clock            (clock),
    .reset            (reset),
    .squash           (squash),
    .retire_valid     (retire_valid),
    .rename_prn_valid (rename_prn_valid),
    .free_count       (free_count)
);

//--- sim/rename_unit_tb.sv
`timescale 1ns/100ps
`include "rename_cfg.svh"

module rename_unit_tb;

    import reg_types_pkg::*;
    import free_list_pkg::*;

    localparam string STIM_FILE    = "sim/rename_stimulus.txt";
    localparam int    CLOCK_PERIOD = 40;
    localparam int    RESET_CYCLES = 8;
    localparam int    NUM_FIELDS   = 15;

    logic          clock;
    logic          reset;
    logic [`N-1:0] rename_valid;
    arn_t [`N-1:0] rename_arn;
    logic [`N-1:0] retire_valid;
    arn_t [`N-1:0] retire_arn;
    prn_t [`N-1:0] retire_prn;
    logic          squash;
    prn_t [`N-1:0] rename_prn;
    logic [`N-1:0] rename_prn_valid;
    prn_t [`N-1:0] rename_old_prn;
    fl_count_t     free_count;

    int mismatch_count = 0;
    int unreadable_count = 0;
    int applied_count = 0;

    rename_unit rename_unit_i (
        .clock            (clock),
        .reset            (reset),
        .rename_valid     (rename_valid),
        .rename_arn       (rename_arn),
        .retire_valid     (retire_valid),
        .retire_arn       (retire_arn),
        .retire_prn       (retire_prn),
        .squash           (squash),
        .rename_prn       (rename_prn),
        .rename_prn_valid (rename_prn_valid),
        .rename_old_prn   (rename_old_prn),
        .free_count       (free_count)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    task automatic count_lines(output int n);
        int    fd;
        string line;
        n  = 0;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            return;
        end
        while ($fgets(line, fd) != 0) begin
            n++;
        end
        $fclose(fd);
    endtask

    task automatic drive_idle();
        rename_valid <= '0;
        rename_arn   <= '0;
        retire_valid <= '0;
        retire_arn   <= '0;
        retire_prn   <= '0;
        squash       <= 1'b0;
    endtask

    task automatic check_outputs(input logic [`N-1:0] req, input logic [`N-1:0] exp_valid,
                                 input prn_t [`N-1:0] exp_prn, input prn_t [`N-1:0] exp_old,
                                 input fl_count_t exp_count);
        assert (rename_prn_valid === exp_valid) else begin
            $display("Mismatch rename_prn_valid: got %h, expected %h",
                     rename_prn_valid, exp_valid);
            mismatch_count++;
        end
        for (int i = 0; i < `N; i++) begin
            if (exp_valid[i]) begin // prn only means something on a granted lane
                assert (rename_prn[i] === exp_prn[i]) else begin
                    $display("Mismatch rename_prn[%0d]: got %h, expected %h",
                             i, rename_prn[i], exp_prn[i]);
                    mismatch_count++;
                end
            end
            if (req[i]) begin
                assert (rename_old_prn[i] === exp_old[i]) else begin
                    $display("Mismatch rename_old_prn[%0d]: got %h, expected %h",
                             i, rename_old_prn[i], exp_old[i]);
                    mismatch_count++;
                end
            end
        end
        assert (free_count === exp_count) else begin
            $display("Mismatch free_count: got %h, expected %h", free_count, exp_count);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        int total;
        total = mismatch_count + unreadable_count + rename_unit_i.protocol_chk.fail_count;
        $display("errors: %0d mismatches, %0d unreadable lines, %0d assertion failures",
                 mismatch_count, unreadable_count, rename_unit_i.protocol_chk.fail_count);
        if (total == 0 && applied_count > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    initial begin : watchdog
        int lines;
        count_lines(lines);
        #((lines + RESET_CYCLES + 20) * CLOCK_PERIOD);
        $display("timeout: the stimulus did not finish in the expected time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin : main
        int          fd;
        int          fields;
        int          line_no;
        string       line;
        logic [31:0] col [NUM_FIELDS];

        reset        = 1'b1;
        rename_valid = '0;
        rename_arn   = '0;
        retire_valid = '0;
        retire_arn   = '0;
        retire_prn   = '0;
        squash       = 1'b0;
        line_no      = 0;

        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("could not open the stimulus file %s", STIM_FILE);
            unreadable_count++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == 8'h0a ||
                    line.getc(0) == 8'h0d) begin
                    continue; // header or blank
                end
                fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                 col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                                 col[14]);
                if (fields != NUM_FIELDS) begin
                    $display("stimulus line %0d could not be read: %0d of %0d fields found",
                             line_no, fields, NUM_FIELDS);
                    unreadable_count++;
                    continue;
                end
                @(posedge clock);
                squash        <= col[0][0];
                rename_valid  <= col[1][`N-1:0];
                rename_arn[0] <= arn_t'(col[2]);
                rename_arn[1] <= arn_t'(col[3]);
                retire_valid  <= col[4][`N-1:0];
                retire_arn[0] <= arn_t'(col[5]);
                retire_arn[1] <= arn_t'(col[6]);
                retire_prn[0] <= prn_t'(col[7]);
                retire_prn[1] <= prn_t'(col[8]);
                #(CLOCK_PERIOD * 3 / 4); // just before the next edge
                check_outputs(col[1][`N-1:0], col[9][`N-1:0],
                              {prn_t'(col[11]), prn_t'(col[10])},
                              {prn_t'(col[13]), prn_t'(col[12])},
                              fl_count_t'(col[14]));
                applied_count++;
            end
            $fclose(fd);
        end

        if (applied_count == 0) begin
            $display("no stimulus lines were applied");
        end
        @(posedge clock);
        drive_idle();
        repeat (2) @(posedge clock); // let the bound assertions see the last cycle
        finish_run();
    end

endmodule

//--- src/free_list.sv
`timescale 1ns/100ps
`include "rename_cfg.svh"

module free_list #(
    parameter int size = `PHYS_REG_SZ
) (
    input  logic                                 clock,
    input  logic                                 reset,

    input  reg_types_pkg::prn_t     [`N-1:0]     push_prn,
    input  logic                    [`N-1:0]     push_valid,
    input  logic                    [`N-1:0]     pop_en,

    input  reg_types_pkg::prn_t     [size-1:0]   restore_entries,
    input  free_list_pkg::fl_ptr_t               restore_head,
    input  free_list_pkg::fl_ptr_t               restore_tail,
    input  free_list_pkg::fl_count_t             restore_count,
    input  logic                                 squash,

    output reg_types_pkg::prn_t     [`N-1:0]     pop_prn,
    output logic                    [`N-1:0]     pop_valid,
    output reg_types_pkg::prn_t     [size-1:0]   entries,
    output free_list_pkg::fl_ptr_t               head,
    output free_list_pkg::fl_ptr_t               tail,
    output free_list_pkg::fl_count_t             count
);

    import reg_types_pkg::*;
    import free_list_pkg::*;

    prn_t      [size-1:0] entries_q;
    prn_t      [size-1:0] next_entries;
    fl_ptr_t              head_q;
    fl_ptr_t              next_head;
    fl_ptr_t              tail_q;
    fl_ptr_t              next_tail;
    fl_count_t            count_q;
    fl_count_t            next_count;

    // step a pointer around the ring
    function automatic fl_ptr_t wrap_inc(input fl_ptr_t ptr);
        if (int'(ptr) == size - 1) begin
            return '0;
        end
        return fl_ptr_t'(ptr + 1'b1);
    endfunction

    always_comb begin
        next_entries = entries_q;
        next_head    = head_q;
        next_tail    = tail_q;
        next_count   = count_q;
        pop_prn      = '0;
        pop_valid    = '0;

        if (squash) begin
            // whole state comes back from the retirement copy
            next_entries = restore_entries;
            next_head    = restore_head;
            next_tail    = restore_tail;
            next_count   = restore_count;
        end else begin
            for (int i = 0; i < `N; i++) begin
                if (pop_en[i] && next_count != '0) begin
                    pop_prn[i]   = entries_q[next_head];
                    pop_valid[i] = 1'b1;
                    next_head    = wrap_inc(next_head);
                    next_count   = next_count - 1'b1;
                end
            end

            // pushes land after this cycle's pops
            for (int i = 0; i < `N; i++) begin
                if (push_valid[i] && int'(next_count) < size) begin
                    next_entries[next_tail] = push_prn[i];
                    next_tail               = wrap_inc(next_tail);
                    next_count              = next_count + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < size; i++) begin
                entries_q[i] <= prn_t'(i);
            end
            head_q  <= fl_ptr_t'(`ARCH_REG_SZ); // low regs hold the initial mappings
            tail_q  <= '0;
            count_q <= fl_count_t'(size - `ARCH_REG_SZ);
        end else begin
            entries_q <= next_entries;
            head_q    <= next_head;
            tail_q    <= next_tail;
            count_q   <= next_count;
        end
    end

    assign entries = entries_q;
    assign head    = head_q;
    assign tail    = tail_q;
    assign count   = count_q;

endmodule

//--- src/free_list_pkg.sv
`include "rename_cfg.svh"

package free_list_pkg;

    // head or tail slot of the circular queue
    typedef logic [`FREE_LIST_PTR_WIDTH-1:0] fl_ptr_t;

    // number of free entries held
    typedef logic [`FREE_LIST_CTR_WIDTH-1:0] fl_count_t;

endpackage

//--- src/map_table.sv
`timescale 1ns/100ps
`include "rename_cfg.svh"

module map_table (
    input  logic                                   clock,
    input  logic                                   reset,
    input  logic                                   squash,

    input  reg_types_pkg::arn_t [`N-1:0]           rename_arn,
    input  reg_types_pkg::prn_t [`N-1:0]           new_prn,
    input  logic                [`N-1:0]           new_valid,

    input  reg_types_pkg::prn_t [`ARCH_REG_SZ-1:0] restore_map,

    output reg_types_pkg::prn_t [`N-1:0]           old_prn
);

    import reg_types_pkg::*;

    prn_t [`ARCH_REG_SZ-1:0] map_q;

    // previous mapping per lane
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            old_prn[i] = map_q[rename_arn[i]];
            // an earlier lane renaming the same reg this cycle wins
            for (int j = 0; j < i; j++) begin
                if (new_valid[j] && rename_arn[j] == rename_arn[i]) begin
                    old_prn[i] = new_prn[j];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < `ARCH_REG_SZ; k++) begin
                map_q[k] <= prn_t'(k); // identity map
            end
        end else if (squash) begin
            map_q <= restore_map;
        end else begin
            // later lanes overwrite earlier ones
            for (int i = 0; i < `N; i++) begin
                if (new_valid[i]) begin
                    map_q[rename_arn[i]] <= new_prn[i];
                end
            end
        end
    end

endmodule

//--- src/reg_types_pkg.sv
`include "rename_cfg.svh"

package reg_types_pkg;

    // architectural register number
    typedef logic [`ARN_WIDTH-1:0] arn_t;

    // physical register number
    typedef logic [`PRN_WIDTH-1:0] prn_t;

endpackage

//--- src/rename_cfg.svh
`ifndef RENAME_CFG_SVH
`define RENAME_CFG_SVH

// rename and retire lanes per cycle
`define N 2

// register file sizes
`define ARCH_REG_SZ 32
`define PHYS_REG_SZ 64

`define ARN_WIDTH 5
`define PRN_WIDTH 6

// free list head/tail index
`define FREE_LIST_PTR_WIDTH 6
// occupancy, one extra bit so a full list of 64 fits
`define FREE_LIST_CTR_WIDTH 7

`endif

//--- src/rename_unit.sv
`timescale 1ns/100ps
`include "rename_cfg.svh"

module rename_unit (
    input  logic                         clock,
    input  logic                         reset,

    input  logic                [`N-1:0] rename_valid,
    input  reg_types_pkg::arn_t [`N-1:0] rename_arn,

    input  logic                [`N-1:0] retire_valid,
    input  reg_types_pkg::arn_t [`N-1:0] retire_arn,
    input  reg_types_pkg::prn_t [`N-1:0] retire_prn,

    input  logic                         squash,

    output reg_types_pkg::prn_t [`N-1:0] rename_prn,
    output logic                [`N-1:0] rename_prn_valid,
    output reg_types_pkg::prn_t [`N-1:0] rename_old_prn,
    output free_list_pkg::fl_count_t     free_count
);

    import reg_types_pkg::*;
    import free_list_pkg::*;

    // regs released by retirement, pushed into both lists
    prn_t [`N-1:0]            freed_prn;
    logic [`N-1:0]            freed_valid;

    // retirement list state, the squash restore source
    prn_t [`PHYS_REG_SZ-1:0]  retire_entries;
    fl_ptr_t                  retire_head;
    fl_ptr_t                  retire_tail;
    fl_count_t                retire_count;

    prn_t [`ARCH_REG_SZ-1:0]  committed_map;

    free_list #(
        .size(`PHYS_REG_SZ)
    ) spec_fl (
        .clock           (clock),
        .reset           (reset),
        .push_prn        (freed_prn),
        .push_valid      (freed_valid),
        .pop_en          (rename_valid),
        .restore_entries (retire_entries),
        .restore_head    (retire_head),
        .restore_tail    (retire_tail),
        .restore_count   (retire_count),
        .squash          (squash),
        .pop_prn         (rename_prn),
        .pop_valid       (rename_prn_valid),
        .entries         (),
        .head            (),
        .tail            (),
        .count           (free_count)
    );

    // pops in allocation order as lanes retire; reloads itself on squash
    free_list #(
        .size(`PHYS_REG_SZ)
    ) retire_fl (
        .clock           (clock),
        .reset           (reset),
        .push_prn        (freed_prn),
        .push_valid      (freed_valid),
        .pop_en          (retire_valid),
        .restore_entries (retire_entries),
        .restore_head    (retire_head),
        .restore_tail    (retire_tail),
        .restore_count   (retire_count),
        .squash          (squash),
        .pop_prn         (),
        .pop_valid       (),
        .entries         (retire_entries),
        .head            (retire_head),
        .tail            (retire_tail),
        .count           (retire_count)
    );

    map_table spec_map (
        .clock       (clock),
        .reset       (reset),
        .squash      (squash),
        .rename_arn  (rename_arn),
        .new_prn     (rename_prn),
        .new_valid   (rename_prn_valid), // only lanes that got a reg
        .restore_map (committed_map),
        .old_prn     (rename_old_prn)
    );

    retire_map commit_map (
        .clock         (clock),
        .reset         (reset),
        .retire_valid  (retire_valid),
        .retire_arn    (retire_arn),
        .retire_prn    (retire_prn),
        .freed_prn     (freed_prn),
        .freed_valid   (freed_valid),
        .committed_map (committed_map)
    );

endmodule

//--- src/retire_map.sv
`timescale 1ns/100ps
`include "rename_cfg.svh"

module retire_map (
    input  logic                                   clock,
    input  logic                                   reset,

    input  logic                [`N-1:0]           retire_valid,
    input  reg_types_pkg::arn_t [`N-1:0]           retire_arn,
    input  reg_types_pkg::prn_t [`N-1:0]           retire_prn,

    output reg_types_pkg::prn_t [`N-1:0]           freed_prn,
    output logic                [`N-1:0]           freed_valid,
    output reg_types_pkg::prn_t [`ARCH_REG_SZ-1:0] committed_map
);

    import reg_types_pkg::*;

    prn_t [`ARCH_REG_SZ-1:0] commit_q;

    // mapping displaced by each retiring lane
    always_comb begin
        for (int i = 0; i < `N; i++) begin
            freed_prn[i] = commit_q[retire_arn[i]];
            for (int j = 0; j < i; j++) begin
                if (retire_valid[j] && retire_arn[j] == retire_arn[i]) begin
                    freed_prn[i] = retire_prn[j]; // lower lane in same bundle
                end
            end
        end
    end

    assign freed_valid   = retire_valid;
    assign committed_map = commit_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int k = 0; k < `ARCH_REG_SZ; k++) begin
                commit_q[k] <= prn_t'(k);
            end
        end else begin
            for (int i = 0; i < `N; i++) begin
                if (retire_valid[i]) begin
                    commit_q[retire_arn[i]] <= retire_prn[i];
                end
            end
        end
    end

endmodule

//--- vlog.f
+incdir+src
src/reg_types_pkg.sv
src/free_list_pkg.sv
src/free_list.sv
src/map_table.sv
src/retire_map.sv
src/rename_unit.sv
sim/rename_unit_checker.sv
sim/rename_unit_tb.sv
